/* source/rvDefs.svh */
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// Core-wide sizing shared by packages and RTL

// Data path and address width
`define XLEN 32

// Integer register file depth, x0 included
`define NREGS 32

// Address of the first fetch after reset release
`define RESET_PC 32'h0000_0000

`endif

/* source/rvIsaPkg.sv */
package rvIsaPkg;

    // Major opcodes of the supported RV32I subset
    typedef enum logic [6:0] {
        OPC_LOAD   = 7'b0000011,  // LB LH LW LBU LHU
        OPC_STORE  = 7'b0100011,  // SB SH SW
        OPC_BRANCH = 7'b1100011,  // BEQ BNE BLT BGE BLTU BGEU
        OPC_JAL    = 7'b1101111,  // J type
        OPC_JALR   = 7'b1100111,  // I type jump
        OPC_LUI    = 7'b0110111,  // U type
        OPC_AUIPC  = 7'b0010111,  // U type, pc relative
        OPC_OPIMM  = 7'b0010011,  // Register-immediate ALU
        OPC_OP     = 7'b0110011   // Register-register ALU
    } opcodeE;

    // funct3 named after the ALU ops, one value per code
    typedef enum logic [2:0] {
        F3_ADD  = 3'b000,  // ADD SUB ADDI
        F3_SLL  = 3'b001,  // Shift left
        F3_SLT  = 3'b010,  // Signed less-than
        F3_SLTU = 3'b011,  // Unsigned less-than
        F3_XOR  = 3'b100,
        F3_SRL  = 3'b101,  // SRL and SRA, split by funct7
        F3_OR   = 3'b110,
        F3_AND  = 3'b111
    } funct3E;

    // Branch codes share the same 3-bit space
    localparam funct3E F3_BEQ  = F3_ADD;
    localparam funct3E F3_BNE  = F3_SLL;
    localparam funct3E F3_BLT  = F3_XOR;
    localparam funct3E F3_BGE  = F3_SRL;
    localparam funct3E F3_BLTU = F3_OR;
    localparam funct3E F3_BGEU = F3_AND;

    // Load and store widths
    localparam funct3E F3_LB  = F3_ADD;
    localparam funct3E F3_LH  = F3_SLL;
    localparam funct3E F3_LW  = F3_SLT;
    localparam funct3E F3_LBU = F3_XOR;
    localparam funct3E F3_LHU = F3_SRL;
    localparam funct3E F3_SB  = F3_ADD;
    localparam funct3E F3_SH  = F3_SLL;
    localparam funct3E F3_SW  = F3_SLT;

    // Only two funct7 patterns are legal on RV32I ALU ops
    typedef enum logic [6:0] {
        F7_BASE = 7'b0000000,
        F7_ALT  = 7'b0100000   // SUB, SRA, SRAI
    } funct7E;

    // R-type field layout, other formats reuse the same bits
    typedef struct packed {
        logic [6:0] funct7;   // Also upper immediate bits
        logic [4:0] rs2;
        logic [4:0] rs1;
        funct3E     funct3;
        logic [4:0] rd;
        opcodeE     opcode;
    } instrT;

endpackage

/* source/rvCtrlPkg.sv */
`include "rvDefs.svh"

package rvCtrlPkg;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASSB   // LUI, operand B straight through
    } aluOpE;

    // Unsigned compares keep their own codes
    typedef enum logic [2:0] {
        BR_NONE,
        BR_EQ,
        BR_NE,
        BR_LT,
        BR_GE,
        BR_LTU,
        BR_GEU
    } branchE;

    typedef enum logic [1:0] {
        WB_ALU,     // ALU result
        WB_MEM,     // Aligned load data
        WB_LINK,    // pc+4 for JAL/JALR
        WB_PCIMM    // AUIPC
    } wbSelE;

    typedef enum logic [1:0] {
        SZ_BYTE,
        SZ_HALF,
        SZ_WORD
    } sizeE;

    typedef struct packed {
        aluOpE  aluOp;
        logic   aluSrcImm;      // Operand B from imm, else rs2
        branchE branch;
        logic   jal;
        logic   jalr;
        wbSelE  wbSel;
        logic   regWrite;
        logic   memWrite;
        logic   memRead;
        sizeE   size;           // Access width for loads and stores
        logic   loadUnsigned;   // Zero-extend instead of sign-extend
    } ctrlT;

    typedef struct packed {
        logic [`XLEN-1:0]   addr;
        logic [`XLEN-1:0]   wdata;   // Already shifted into its lanes
        logic [`XLEN/8-1:0] byteEn;
        logic               write;
    } memReqT;

endpackage

/* source/rvDecoder.sv */
`include "rvDefs.svh"

module rvDecoder (
    input  rvIsaPkg::instrT  instr,
    output rvCtrlPkg::ctrlT  ctrl,
    output logic [`XLEN-1:0] imm,
    output logic [4:0]       rs1,
    output logic [4:0]       rs2,
    output logic [4:0]       rd
);

    logic [31:0]      word;      // Flat view for immediate slicing
    logic [`XLEN-1:0] immI;
    logic [`XLEN-1:0] immS;
    logic [`XLEN-1:0] immB;
    logic [`XLEN-1:0] immU;
    logic [`XLEN-1:0] immJ;
    logic             f7Base;    // funct7 all zero
    logic             f7Alt;     // funct7 selects SUB/SRA
    logic             isShiftR;  // SRL/SRA funct3

    // ALU op from funct3, alt picks SUB or SRA
    function automatic rvCtrlPkg::aluOpE aluFromF3(rvIsaPkg::funct3E f3, logic alt);
        rvCtrlPkg::aluOpE op;
        case (f3)
            rvIsaPkg::F3_ADD:  op = alt ? rvCtrlPkg::ALU_SUB : rvCtrlPkg::ALU_ADD;
            rvIsaPkg::F3_SLL:  op = rvCtrlPkg::ALU_SLL;
            rvIsaPkg::F3_SLT:  op = rvCtrlPkg::ALU_SLT;
            rvIsaPkg::F3_SLTU: op = rvCtrlPkg::ALU_SLTU;
            rvIsaPkg::F3_XOR:  op = rvCtrlPkg::ALU_XOR;
            rvIsaPkg::F3_SRL:  op = alt ? rvCtrlPkg::ALU_SRA : rvCtrlPkg::ALU_SRL;
            rvIsaPkg::F3_OR:   op = rvCtrlPkg::ALU_OR;
            default:           op = rvCtrlPkg::ALU_AND;
        endcase
        return op;
    endfunction

    assign word = instr;
    assign rs1  = instr.rs1;
    assign rs2  = instr.rs2;
    assign rd   = instr.rd;

    assign f7Base   = instr.funct7 == rvIsaPkg::F7_BASE;
    assign f7Alt    = instr.funct7 == rvIsaPkg::F7_ALT;
    assign isShiftR = instr.funct3 == rvIsaPkg::F3_SRL;

    assign immI = {{20{word[31]}}, word[31:20]};
    assign immS = {{20{word[31]}}, word[31:25], word[11:7]};
    assign immB = {{19{word[31]}}, word[31], word[7], word[30:25], word[11:8], 1'b0};
    assign immU = {word[31:12], 12'b0};
    assign immJ = {{11{word[31]}}, word[31], word[19:12], word[20], word[30:21], 1'b0};

    always_comb begin
        ctrl = '0;  // Unknown opcode falls through as a no-op
        imm  = '0;
        case (instr.opcode)
            rvIsaPkg::OPC_LOAD: begin
                imm            = immI;
                ctrl.aluSrcImm = 1'b1;  // Address is rs1 + imm
                ctrl.memRead   = 1'b1;
                ctrl.regWrite  = 1'b1;
                ctrl.wbSel     = rvCtrlPkg::WB_MEM;
                case (instr.funct3)
                    rvIsaPkg::F3_LB:  ctrl.size = rvCtrlPkg::SZ_BYTE;
                    rvIsaPkg::F3_LH:  ctrl.size = rvCtrlPkg::SZ_HALF;
                    rvIsaPkg::F3_LW:  ctrl.size = rvCtrlPkg::SZ_WORD;
                    rvIsaPkg::F3_LBU: begin
                        ctrl.size         = rvCtrlPkg::SZ_BYTE;
                        ctrl.loadUnsigned = 1'b1;
                    end
                    rvIsaPkg::F3_LHU: begin
                        ctrl.size         = rvCtrlPkg::SZ_HALF;
                        ctrl.loadUnsigned = 1'b1;
                    end
                    default: ctrl = '0;  // Reserved width
                endcase
            end
            rvIsaPkg::OPC_STORE: begin
                imm            = immS;
                ctrl.aluSrcImm = 1'b1;
                ctrl.memWrite  = 1'b1;
                case (instr.funct3)
                    rvIsaPkg::F3_SB: ctrl.size = rvCtrlPkg::SZ_BYTE;
                    rvIsaPkg::F3_SH: ctrl.size = rvCtrlPkg::SZ_HALF;
                    rvIsaPkg::F3_SW: ctrl.size = rvCtrlPkg::SZ_WORD;
                    default:         ctrl = '0;
                endcase
            end
            rvIsaPkg::OPC_BRANCH: begin
                imm = immB;
                case (instr.funct3)
                    rvIsaPkg::F3_BEQ:  ctrl.branch = rvCtrlPkg::BR_EQ;
                    rvIsaPkg::F3_BNE:  ctrl.branch = rvCtrlPkg::BR_NE;
                    rvIsaPkg::F3_BLT:  ctrl.branch = rvCtrlPkg::BR_LT;
                    rvIsaPkg::F3_BGE:  ctrl.branch = rvCtrlPkg::BR_GE;
                    rvIsaPkg::F3_BLTU: ctrl.branch = rvCtrlPkg::BR_LTU;
                    rvIsaPkg::F3_BGEU: ctrl.branch = rvCtrlPkg::BR_GEU;
                    default:           ctrl.branch = rvCtrlPkg::BR_NONE;
                endcase
            end
            rvIsaPkg::OPC_JAL: begin
                imm           = immJ;
                ctrl.jal      = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.wbSel    = rvCtrlPkg::WB_LINK;
            end
            rvIsaPkg::OPC_JALR: begin
                imm = immI;
                if (instr.funct3 == rvIsaPkg::F3_ADD) begin
                    ctrl.jalr      = 1'b1;
                    ctrl.aluSrcImm = 1'b1;  // Target from ALU add
                    ctrl.regWrite  = 1'b1;
                    ctrl.wbSel     = rvCtrlPkg::WB_LINK;
                end
            end
            rvIsaPkg::OPC_LUI: begin
                imm            = immU;
                ctrl.aluOp     = rvCtrlPkg::ALU_PASSB;
                ctrl.aluSrcImm = 1'b1;
                ctrl.regWrite  = 1'b1;
            end
            rvIsaPkg::OPC_AUIPC: begin
                imm           = immU;
                ctrl.regWrite = 1'b1;
                ctrl.wbSel    = rvCtrlPkg::WB_PCIMM;  // pc + imm from execute
            end
            rvIsaPkg::OPC_OPIMM: begin
                imm            = immI;
                ctrl.aluOp     = aluFromF3(instr.funct3, f7Alt && isShiftR);
                ctrl.aluSrcImm = 1'b1;
                // Shift immediates carry funct7 in imm[11:5]
                ctrl.regWrite  = (instr.funct3 == rvIsaPkg::F3_SLL) ? f7Base :
                                 isShiftR ? (f7Base || f7Alt) : 1'b1;
            end
            rvIsaPkg::OPC_OP: begin
                ctrl.aluOp    = aluFromF3(instr.funct3, f7Alt);
                ctrl.regWrite = f7Base ||
                                (f7Alt && (isShiftR || instr.funct3 == rvIsaPkg::F3_ADD));
            end
            default: ;
        endcase
    end

    // No decode arm may write memory and a register together
    a_storeNoWb: assert property (@(instr) !(ctrl.memWrite && ctrl.regWrite))
        else $error("decoder set memWrite and regWrite together");

endmodule

/* source/rvExecute.sv */
`include "rvDefs.svh"

module rvExecute (
    input  logic [`XLEN-1:0]  pc,
    input  rvCtrlPkg::ctrlT   ctrl,
    input  logic [`XLEN-1:0]  imm,
    input  logic [`XLEN-1:0]  rs1Data,
    input  logic [`XLEN-1:0]  rs2Data,
    output logic [`XLEN-1:0]  aluResult,
    output logic [`XLEN-1:0]  linkPc,
    output logic [`XLEN-1:0]  pcImm,
    output logic [`XLEN-1:0]  nextPc,
    output rvCtrlPkg::memReqT memReq
);

    logic [`XLEN-1:0]   opB;
    logic [4:0]         shamt;     // RV32 shift amount
    logic               taken;     // Branch condition met
    logic [1:0]         addrLow;   // Byte lane of the access
    logic [`XLEN/8-1:0] laneMask;  // Enables before lane shift

    assign opB   = ctrl.aluSrcImm ? imm : rs2Data;
    assign shamt = opB[4:0];

    always_comb begin
        case (ctrl.aluOp)
            rvCtrlPkg::ALU_ADD:   aluResult = rs1Data + opB;
            rvCtrlPkg::ALU_SUB:   aluResult = rs1Data - opB;
            rvCtrlPkg::ALU_SLL:   aluResult = rs1Data << shamt;
            rvCtrlPkg::ALU_SLT:   aluResult = {{(`XLEN-1){1'b0}}, $signed(rs1Data) < $signed(opB)};
            rvCtrlPkg::ALU_SLTU:  aluResult = {{(`XLEN-1){1'b0}}, rs1Data < opB};
            rvCtrlPkg::ALU_XOR:   aluResult = rs1Data ^ opB;
            rvCtrlPkg::ALU_SRL:   aluResult = rs1Data >> shamt;
            rvCtrlPkg::ALU_SRA:   aluResult = $signed(rs1Data) >>> shamt;  // Keeps sign
            rvCtrlPkg::ALU_OR:    aluResult = rs1Data | opB;
            rvCtrlPkg::ALU_AND:   aluResult = rs1Data & opB;
            rvCtrlPkg::ALU_PASSB: aluResult = opB;                        // LUI
            default:              aluResult = '0;
        endcase
    end

    // Branches compare rs1 with rs2 directly, the ALU stays free
    always_comb begin
        case (ctrl.branch)
            rvCtrlPkg::BR_EQ:  taken = rs1Data == rs2Data;
            rvCtrlPkg::BR_NE:  taken = rs1Data != rs2Data;
            rvCtrlPkg::BR_LT:  taken = $signed(rs1Data) < $signed(rs2Data);
            rvCtrlPkg::BR_GE:  taken = $signed(rs1Data) >= $signed(rs2Data);
            rvCtrlPkg::BR_LTU: taken = rs1Data < rs2Data;
            rvCtrlPkg::BR_GEU: taken = rs1Data >= rs2Data;
            default:           taken = 1'b0;
        endcase
    end

    assign linkPc = pc + `XLEN'd4;
    assign pcImm  = pc + imm;

    always_comb begin
        if (ctrl.jalr) begin
            nextPc = {aluResult[`XLEN-1:1], 1'b0};  // rs1 + imm, bit 0 dropped
        end else if (ctrl.jal || taken) begin
            nextPc = pcImm;
        end else begin
            nextPc = linkPc;  // Also the path for unknown opcodes
        end
    end

    assign addrLow = aluResult[1:0];

    always_comb begin
        case (ctrl.size)
            rvCtrlPkg::SZ_BYTE: laneMask = 4'b0001;
            rvCtrlPkg::SZ_HALF: laneMask = 4'b0011;
            default:            laneMask = 4'b1111;
        endcase
    end

    assign memReq.addr   = aluResult;
    assign memReq.wdata  = rs2Data << {addrLow, 3'b000};  // Move data into its lane
    assign memReq.byteEn = (ctrl.memRead || ctrl.memWrite) ? laneMask << addrLow : '0;
    assign memReq.write  = ctrl.memWrite;

    // Jump and branch targets must stay word aligned
    a_pcAligned: assert property (@(pc)
        (ctrl.jal || ctrl.branch != rvCtrlPkg::BR_NONE) |-> (nextPc[1:0] == 2'b00))
        else $error("misaligned target 0x%08h", nextPc);

endmodule

/* source/rvResult.sv */
`include "rvDefs.svh"

module rvResult (
    input  logic             clk,
    input  logic             arstN,
    input  rvCtrlPkg::ctrlT  ctrl,
    input  logic [4:0]       rd,
    input  logic [4:0]       rs1,
    input  logic [4:0]       rs2,
    input  logic [`XLEN-1:0] aluResult,
    input  logic [`XLEN-1:0] linkPc,
    input  logic [`XLEN-1:0] pcImm,
    input  logic [`XLEN-1:0] memRdata,
    input  logic [1:0]       memAddrLow,
    output logic [`XLEN-1:0] rs1Data,
    output logic [`XLEN-1:0] rs2Data
);

    logic [`XLEN-1:0] regFile [`NREGS];
    logic [`XLEN-1:0] laneWord;  // Addressed byte/half moved to bit 0
    logic [`XLEN-1:0] loadData;  // Extended load value
    logic [`XLEN-1:0] wbData;
    logic             wrEn;      // Real write, never x0

    assign laneWord = memRdata >> {memAddrLow, 3'b000};

    always_comb begin
        case (ctrl.size)
            rvCtrlPkg::SZ_BYTE: begin
                if (ctrl.loadUnsigned) begin
                    loadData = {{(`XLEN-8){1'b0}}, laneWord[7:0]};  // LBU
                end else begin
                    loadData = {{(`XLEN-8){laneWord[7]}}, laneWord[7:0]};
                end
            end
            rvCtrlPkg::SZ_HALF: begin
                if (ctrl.loadUnsigned) begin
                    loadData = {{(`XLEN-16){1'b0}}, laneWord[15:0]};  // LHU
                end else begin
                    loadData = {{(`XLEN-16){laneWord[15]}}, laneWord[15:0]};
                end
            end
            default: loadData = memRdata;  // LW, no shift needed
        endcase
    end

    always_comb begin
        case (ctrl.wbSel)
            rvCtrlPkg::WB_ALU:  wbData = aluResult;
            rvCtrlPkg::WB_MEM:  wbData = loadData;
            rvCtrlPkg::WB_LINK: wbData = linkPc;    // JAL/JALR return address
            default:            wbData = pcImm;     // AUIPC
        endcase
    end

    assign wrEn = ctrl.regWrite && (rd != 5'd0);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < `NREGS; i++) begin
                regFile[i] <= '0;
            end
        end else if (wrEn) begin
            regFile[rd] <= wbData;
        end
    end

    // x0 stays zero because it is never written
    assign rs1Data = regFile[rs1];
    assign rs2Data = regFile[rs2];

    // Reset plus the write guard keep x0 reading zero on both ports
    a_x0Zero: assert property (@(posedge clk) disable iff (!arstN)
        ((rs1 == 5'd0) -> (rs1Data == '0)) && ((rs2 == 5'd0) -> (rs2Data == '0)))
        else $error("x0 read back nonzero");

endmodule

/* source/rvCore.sv */
`include "rvDefs.svh"

module rvCore (
    input  logic              clk,
    input  logic              arstN,
    output logic [`XLEN-1:0]  pc,
    input  rvIsaPkg::instrT   instr,
    output rvCtrlPkg::memReqT memReq,
    input  logic [`XLEN-1:0]  memRdata
);

    rvCtrlPkg::ctrlT  decCtrl;  // Straight from the decoder
    rvCtrlPkg::ctrlT  ctrl;     // Store strobe held off in reset
    logic [`XLEN-1:0] imm;
    logic [4:0]       rs1;
    logic [4:0]       rs2;
    logic [4:0]       rd;
    logic [`XLEN-1:0] rs1Data;
    logic [`XLEN-1:0] rs2Data;
    logic [`XLEN-1:0] aluResult;
    logic [`XLEN-1:0] linkPc;
    logic [`XLEN-1:0] pcImm;
    logic [`XLEN-1:0] nextPc;

    // The only state outside the register file
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc <= `RESET_PC;
        end else begin
            pc <= nextPc;  // One instruction per clock
        end
    end

    always_comb begin
        ctrl          = decCtrl;
        ctrl.memWrite = decCtrl.memWrite && arstN;  // No store while in reset
    end

    rvDecoder uDecoder (
        .instr (instr),
        .ctrl  (decCtrl),
        .imm   (imm),
        .rs1   (rs1),
        .rs2   (rs2),
        .rd    (rd)
    );

    rvExecute uExecute (
        .pc        (pc),
        .ctrl      (ctrl),
        .imm       (imm),
        .rs1Data   (rs1Data),
        .rs2Data   (rs2Data),
        .aluResult (aluResult),
        .linkPc    (linkPc),
        .pcImm     (pcImm),
        .nextPc    (nextPc),
        .memReq    (memReq)
    );

    rvResult uResult (
        .clk        (clk),
        .arstN      (arstN),
        .ctrl       (ctrl),
        .rd         (rd),
        .rs1        (rs1),
        .rs2        (rs2),
        .aluResult  (aluResult),
        .linkPc     (linkPc),
        .pcImm      (pcImm),
        .memRdata   (memRdata),
        .memAddrLow (memReq.addr[1:0]),  // Lane for load alignment
        .rs1Data    (rs1Data),
        .rs2Data    (rs2Data)
    );

endmodule

/* verif/rvCoreTb.sv */
`include "rvDefs.svh"

module rvCoreTb;

    logic              clk;
    logic              arstN;
    logic [`XLEN-1:0]  pc;
    rvIsaPkg::instrT   instr;
    rvCtrlPkg::memReqT memReq;
    logic [`XLEN-1:0]  memRdata;
    logic [`XLEN-1:0]  wdataSeen;  // Store data limited to enabled lanes

    logic [31:0]       imem [1024];
    logic [7:0]        dmem [1024];
    logic [31:0]       sreg [32];   // Shadow register file
    logic [31:0]       bpc;         // Build-time pc
    logic [11:0]       stOff;       // Next free word in the store area
    logic [31:0]       lcgState;
    logic [31:0]       pcQ [$];
    string             pcNameQ [$];
    rvCtrlPkg::memReqT stQ [$];
    string             stNameQ [$];
    logic [31:0]       expPc;
    string             pcName;
    rvCtrlPkg::memReqT expSt;
    string             stName;
    logic              pcValid;
    logic              stValid;
    int                cycles;

    rvCore DUT (
        .clk      (clk),
        .arstN    (arstN),
        .pc       (pc),
        .instr    (instr),
        .memReq   (memReq),
        .memRdata (memRdata)
    );

    always #20 clk = ~clk;

    assign instr     = imem[pc[11:2]];  // Fetch answers in the same cycle
    assign memRdata  = {dmem[{memReq.addr[9:2], 2'd3}], dmem[{memReq.addr[9:2], 2'd2}],
                        dmem[{memReq.addr[9:2], 2'd1}], dmem[{memReq.addr[9:2], 2'd0}]};
    assign wdataSeen = memReq.wdata & laneBits(memReq.byteEn);

    always @(posedge clk) begin
        if (memReq.write) begin
            for (int b = 0; b < 4; b++) begin
                if (memReq.byteEn[b]) begin
                    dmem[{memReq.addr[9:2], 2'(b)}] <= memReq.wdata[8*b +: 8];
                end
            end
        end
    end

    // Expectations for the instruction now presented, checked on the next edge
    always @(negedge clk) begin
        if (arstN) begin
            pcValid = pcQ.size() > 0;
            if (pcValid) begin
                expPc  = pcQ.pop_front();
                pcName = pcNameQ.pop_front();
            end
            stValid = memReq.write && stQ.size() > 0;
            if (stValid) begin
                expSt  = stQ.pop_front();
                stName = stNameQ.pop_front();
            end
        end
    end

    a_resetState: assert property (@(posedge clk) !arstN |-> (pc == `RESET_PC && !memReq.write))
        else abortRun($sformatf("** Error reset: pc/write expected 0x%08h/0 actual 0x%08h/%b",
                                `RESET_PC, $sampled(pc), $sampled(memReq.write)));
    a_pcTrace: assert property (@(posedge clk) disable iff (!arstN) pcValid |-> pc == expPc)
        else abortRun($sformatf("** Error %s: pc expected 0x%08h actual 0x%08h",
                                pcName, expPc, $sampled(pc)));
    a_storeSeen: assert property (@(posedge clk) disable iff (!arstN) memReq.write |-> stValid)
        else abortRun($sformatf("A store to 0x%08h happened that no test expected",
                                $sampled(memReq.addr)));
    a_storeValue: assert property (@(posedge clk) disable iff (!arstN)
        (memReq.write && stValid) |->
        (memReq.addr == expSt.addr && memReq.byteEn == expSt.byteEn && wdataSeen == expSt.wdata))
        else abortRun($sformatf("** Error %s: store expected %08h/%08h/%b actual %08h/%08h/%b",
                                stName, expSt.addr, expSt.wdata, expSt.byteEn,
                                $sampled(memReq.addr), $sampled(wdataSeen),
                                $sampled(memReq.byteEn)));

    task automatic abortRun(input string what);
        $display("%s", what);
        $display("Regression failed");
        $fatal(1);
    endtask

    function automatic logic [31:0] nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    function automatic logic [31:0] laneBits(logic [3:0] be);
        return {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
    endfunction

    function automatic logic [31:0] rType(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3, logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, rvIsaPkg::OPC_OP};
    endfunction

    function automatic logic [31:0] iType(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                          logic [4:0] rd, logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] sType(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], rvIsaPkg::OPC_STORE};
    endfunction

    function automatic logic [31:0] bType(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rvIsaPkg::OPC_BRANCH};
    endfunction

    function automatic logic [31:0] uType(logic [19:0] imm, logic [4:0] rd, logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] jType(logic [20:0] imm, logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rvIsaPkg::OPC_JAL};
    endfunction

    // RV32I integer semantics, shifts use the low 5 bits of operand B
    function automatic logic [31:0] aluRef(logic [2:0] f3, logic alt, logic [31:0] a,
                                           logic [31:0] b);
        case (f3)
            3'd0: begin
                if (alt) return a - b;
                return a + b;
            end
            3'd1: return a << b[4:0];
            3'd2: return {31'b0, $signed(a) < $signed(b)};
            3'd3: return {31'b0, a < b};
            3'd4: return a ^ b;
            3'd5: begin
                if (alt) return $signed(a) >>> b[4:0];  // Sign fills from the left
                return a >> b[4:0];
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic brRef(logic [2:0] f3, logic [31:0] a, logic [31:0] b);
        case (f3)
            3'd0: return a == b;
            3'd1: return a != b;
            3'd4: return $signed(a) < $signed(b);
            3'd5: return $signed(a) >= $signed(b);
            3'd6: return a < b;
            default: return a >= b;
        endcase
    endfunction

    function automatic logic [31:0] loadRef(logic [2:0] f3, logic [31:0] addr);
        int          a;
        logic [7:0]  bt;
        logic [15:0] hf;
        a  = addr[9:0];
        bt = dmem[a];
        hf = {dmem[a+1], dmem[a]};
        case (f3)
            3'd0: return {{24{bt[7]}}, bt};
            3'd1: return {{16{hf[15]}}, hf};
            3'd4: return {24'b0, bt};
            3'd5: return {16'b0, hf};
            default: return {dmem[a+3], dmem[a+2], hf};
        endcase
    endfunction

    task automatic emit(logic [31:0] w, string name);
        imem[bpc[11:2]] = w;
        pcQ.push_back(bpc);  // Every executed word is also a pc check
        pcNameQ.push_back(name);
        bpc = bpc + 4;
    endtask

    task automatic skipSlot();
        imem[bpc[11:2]] = 32'h0000_0013;  // Wrong-path NOP
        bpc = bpc + 4;
    endtask

    task automatic putWord(logic [31:0] addr, logic [31:0] w);
        for (int b = 0; b < 4; b++) begin
            dmem[addr[9:0] + b] = w[8*b +: 8];
        end
    endtask

    task automatic expectStore(logic [31:0] addr, logic [31:0] data, logic [3:0] be, string name);
        rvCtrlPkg::memReqT r;
        r.addr   = addr;
        r.wdata  = data & laneBits(be);
        r.byteEn = be;
        r.write  = 1'b1;
        stQ.push_back(r);
        stNameQ.push_back(name);
    endtask

    // Results become visible through a word store into the area at x2
    task automatic storeWord(logic [4:0] rs, string name);
        emit(sType(stOff, rs, 5'd2, rvIsaPkg::F3_SW), name);
        expectStore(sreg[2] + stOff, sreg[rs], 4'hf, name);
        stOff = stOff + 4;
    endtask

    task automatic opR(logic [2:0] f3, logic alt, logic [4:0] rd, logic [4:0] rs1,
                       logic [4:0] rs2, string name);
        emit(rType(alt ? rvIsaPkg::F7_ALT : rvIsaPkg::F7_BASE, rs2, rs1, f3, rd), name);
        if (rd != 5'd0) sreg[rd] = aluRef(f3, alt, sreg[rs1], sreg[rs2]);
        storeWord(rd, name);
    endtask

    task automatic opI(logic [2:0] f3, logic [4:0] rd, logic [4:0] rs1, logic [11:0] imm,
                       string name);
        emit(iType(imm, rs1, f3, rd, rvIsaPkg::OPC_OPIMM), name);
        if (rd != 5'd0) sreg[rd] = aluRef(f3, f3 == 3'd5 && imm[10], sreg[rs1],
                                          {{20{imm[11]}}, imm});
        storeWord(rd, name);
    endtask

    task automatic loadCheck(logic [2:0] f3, logic [11:0] off, string name);
        emit(iType(off, 5'd1, f3, 5'd9, rvIsaPkg::OPC_LOAD), name);
        sreg[9] = loadRef(f3, sreg[1] + off);
        storeWord(5'd9, name);
    endtask

    task automatic storeLane(logic [2:0] f3, logic [11:0] off, string name);
        logic [3:0] be;
        be = (f3 == 3'd0) ? 4'b0001 : (f3 == 3'd1) ? 4'b0011 : 4'b1111;
        emit(sType(stOff + off, 5'd5, 5'd2, f3), name);
        expectStore(sreg[2] + stOff + off, sreg[5] << (8 * off), be << off[1:0], name);
        stOff = stOff + 4;
    endtask

    // Taken branches land two words ahead, skipping one slot
    task automatic branchCheck(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2, string name);
        emit(bType(13'd8, rs2, rs1, f3), name);
        if (brRef(f3, sreg[rs1], sreg[rs2])) skipSlot();
        else emit(32'h0000_0000, {name, " fall-through"});  // Unknown opcode acts as NOP
    endtask

    task automatic buildProgram();
        logic [31:0] w0;
        logic [31:0] r;
        logic [31:0] p;
        lcgState = 32'd61;
        bpc      = `RESET_PC;
        stOff    = '0;
        for (int i = 0; i < 1024; i++) begin
            imem[i] = '0;
            dmem[i] = '0;
        end
        for (int i = 0; i < 32; i++) sreg[i] = '0;
        w0 = nextRand();
        putWord(32'h100, w0);
        putWord(32'h104, nextRand());
        putWord(32'h108, w0 ^ 32'h8000_0000);  // Same value, other sign
        emit(iType(12'h100, 5'd0, 3'd0, 5'd1, rvIsaPkg::OPC_OPIMM), "setup x1");
        sreg[1] = 32'h100;
        emit(iType(12'h200, 5'd0, 3'd0, 5'd2, rvIsaPkg::OPC_OPIMM), "setup x2");
        sreg[2] = 32'h200;
        for (int k = 0; k < 3; k++) begin  // Operands into x5..x7
            emit(iType(12'(4 * k), 5'd1, 3'd2, 5'(5 + k), rvIsaPkg::OPC_LOAD), "setup load");
            sreg[5 + k] = loadRef(3'd2, 32'h100 + 4 * k);
        end
        for (int f = 0; f < 8; f++) begin
            opR(3'(f), 1'b0, 5'd8, 5'd5, 5'd6, $sformatf("OP f3=%0d", f));
            if (f == 0 || f == 5) opR(3'(f), 1'b1, 5'd8, 5'd5, 5'd6, $sformatf("OP alt f3=%0d", f));
            r = nextRand();
            if (f == 1 || f == 5) opI(3'(f), 5'd8, 5'd5, {7'b0, r[4:0]}, $sformatf("IMM f3=%0d", f));
            else opI(3'(f), 5'd8, 5'd5, r[11:0], $sformatf("IMM f3=%0d", f));
        end
        opI(3'd5, 5'd8, 5'd7, {7'b0100000, r[9:5]}, "SRAI");
        opR(3'd2, 1'b0, 5'd8, 5'd5, 5'd7, "SLT sign split");
        opR(3'd3, 1'b0, 5'd8, 5'd5, 5'd7, "SLTU sign split");
        opR(3'd0, 1'b0, 5'd0, 5'd5, 5'd6, "x0 write");
        for (int off = 0; off < 4; off++) begin
            loadCheck(3'd0, 12'(off), $sformatf("LB +%0d", off));
            loadCheck(3'd4, 12'(off), $sformatf("LBU +%0d", off));
            storeLane(3'd0, 12'(off), $sformatf("SB +%0d", off));
            if (off[0] == 1'b0) begin
                loadCheck(3'd1, 12'(off), $sformatf("LH +%0d", off));
                loadCheck(3'd5, 12'(off), $sformatf("LHU +%0d", off));
                storeLane(3'd1, 12'(off), $sformatf("SH +%0d", off));
            end
        end
        loadCheck(3'd2, 12'd0, "LW");
        storeLane(3'd2, 12'd0, "SW");
        for (int f = 0; f < 8; f++) begin
            if (f != 2 && f != 3) begin
                branchCheck(3'(f), 5'd5, 5'd5, $sformatf("BR f3=%0d equal", f));
                branchCheck(3'(f), 5'd5, 5'd7, $sformatf("BR f3=%0d fwd", f));
                branchCheck(3'(f), 5'd7, 5'd5, $sformatf("BR f3=%0d rev", f));
            end
        end
        p = bpc;
        emit(jType(21'd12, 5'd10), "JAL");
        sreg[10] = p + 4;
        skipSlot();
        skipSlot();
        storeWord(5'd10, "JAL link");
        p = bpc;
        emit(uType(20'h0, 5'd11, rvIsaPkg::OPC_AUIPC), "AUIPC zero");
        sreg[11] = p;
        emit(iType(12'd13, 5'd11, 3'd0, 5'd12, rvIsaPkg::OPC_JALR), "JALR");  // Odd target
        sreg[12] = p + 8;
        skipSlot();
        storeWord(5'd11, "AUIPC zero");
        storeWord(5'd12, "JALR link");
        r = nextRand();
        emit(uType(r[31:12], 5'd13, rvIsaPkg::OPC_LUI), "LUI");
        sreg[13] = {r[31:12], 12'b0};
        storeWord(5'd13, "LUI");
        p = bpc;
        emit(uType(20'h80001, 5'd13, rvIsaPkg::OPC_AUIPC), "AUIPC");
        sreg[13] = p + 32'h8000_1000;
        storeWord(5'd13, "AUIPC");
        emit(jType(21'd0, 5'd0), "park loop");  // Spins here after the last check
    endtask

    initial begin
        clk     = 1'b0;
        arstN   = 1'b1;
        pcValid = 1'b0;
        stValid = 1'b0;
        cycles  = 0;
        buildProgram();
        #2 arstN = 1'b0;  // Clean falling edge for the async reset
        repeat (3) @(posedge clk);
        #2 arstN = 1'b1;
        while ((pcQ.size() != 0 || stQ.size() != 0) && cycles < 2000) begin
            @(posedge clk);
            cycles++;
        end
        @(posedge clk);  // Last expectation checked here
        #2;
        if (pcQ.size() != 0 || stQ.size() != 0) begin
            abortRun($sformatf("Timed out with %0d fetches and %0d stores never seen",
                               pcQ.size(), stQ.size()));
        end else begin
            $display("Regression passed");
            $finish;
        end
    end

endmodule

/* rvCore.f */
+incdir+source
source/rvIsaPkg.sv
source/rvCtrlPkg.sv
source/rvDecoder.sv
source/rvExecute.sv
source/rvResult.sv
source/rvCore.sv
verif/rvCoreTb.sv
